// File: include/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

// datapath and pc width
`define EX_XLEN  64
// instruction word width
`define EX_ILEN  32
// decoded opcode width, as sent by decode
`define EX_OPC_W 24

// register-register ops
`define OPC_ADD    24'h004000
`define OPC_SUB    24'h005000
`define OPC_SLL    24'h006000
`define OPC_SLT    24'h007000
`define OPC_SLTU   24'h008000
`define OPC_XOR    24'h009000
`define OPC_SRL    24'h010000
`define OPC_OR     24'h012000
`define OPC_AND    24'h013000

// word immediate shifts
`define OPC_SLLIW  24'h014000
`define OPC_SRLIW  24'h015000
`define OPC_SRAIW  24'h016000

// word register ops
`define OPC_ADDW   24'h017000
`define OPC_SUBW   24'h018000
`define OPC_SLLW   24'h019000
`define OPC_SRLW   24'h01a000
`define OPC_SRAW   24'h01b000

// upper immediates and jal
`define OPC_LUI    24'h000100
`define OPC_AUIPC  24'h000200
`define OPC_JAL    24'h000300

// 64-bit immediate shifts
`define OPC_SLLI   24'h000400
`define OPC_SRLI   24'h000800
`define OPC_SRAI   24'h000c00

// jalr and conditional branches
`define OPC_JALR   24'd4
`define OPC_BEQ    24'd5
`define OPC_BNE    24'd6
`define OPC_BLT    24'd7
`define OPC_BGE    24'd8
`define OPC_BLTU   24'd9
`define OPC_BGEU   24'd10

// immediate alu ops
`define OPC_ADDI   24'd19
`define OPC_SLTI   24'd20
`define OPC_SLTIU  24'd21
`define OPC_XORI   24'd22
`define OPC_ORI    24'd23
`define OPC_ANDI   24'd24
`define OPC_ADDIW  24'd47

// system
`define OPC_CSRRW  24'd49
`define OPC_CSRRS  24'd50
`define OPC_ECALL  24'h200000
`define OPC_MRET   24'h500000

// machine csr addresses
`define CSR_MSTATUS 12'h300
`define CSR_MTVEC   12'h305
`define CSR_MEPC    12'h341
`define CSR_MCAUSE  12'h342

// environment call from m-mode
`define MCAUSE_ECALL_M 64'd11

`endif

// File: src/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

    // decode to execute bundle
    typedef struct packed {
        logic [`EX_XLEN-1:0]  pc;
        logic [`EX_ILEN-1:0]  inst;
        logic [`EX_OPC_W-1:0] opcode;
        logic [`EX_XLEN-1:0]  src_a;
        logic [`EX_XLEN-1:0]  src_b;
        logic [`EX_XLEN-1:0]  imm;
    } ex_in_t;

    // alu operation, gaps in the encoding are unused
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLT  = 4'd2,
        ALU_SLTU = 4'd3,
        ALU_AND  = 4'd4,
        ALU_OR   = 4'd6,
        ALU_XOR  = 4'd7,
        ALU_SLL  = 4'd8,
        ALU_SRL  = 4'd9,
        ALU_SRA  = 4'd10
    } alu_mode_t;

    // how a 64-bit alu result becomes a W result
    typedef enum logic [1:0] {
        FMT_NONE,
        FMT_SEXT_LOW,
        FMT_SEXT_HIGH
    } word_fmt_t;

    typedef struct packed {
        alu_mode_t mode;
        word_fmt_t word_fmt;
    } alu_ctrl_t;

    // i-type view, imm field holds the csr address
    typedef struct packed {
        logic [11:0] csr;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  op;
    } csr_fmt_t;

    // b-type view with scattered immediate bits
    typedef struct packed {
        logic        imm12;
        logic [5:0]  imm10_5;
        logic [4:0]  rs2;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [3:0]  imm4_1;
        logic        imm11;
        logic [6:0]  op;
    } b_fmt_t;

    typedef union packed {
        csr_fmt_t csr;
        b_fmt_t   b;
    } inst_u;

    // one write port per csr
    typedef struct packed {
        logic                wen;
        logic [`EX_XLEN-1:0] wdata;
    } csr_wr_t;

endpackage

// File: src/ex_operand_sel.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_operand_sel
    import ex_pkg::*;
(
    input  logic [`EX_XLEN-1:0]  pc,
    input  logic [`EX_ILEN-1:0]  inst,
    input  logic [`EX_OPC_W-1:0] opcode,
    input  logic [`EX_XLEN-1:0]  src_a,
    input  logic [`EX_XLEN-1:0]  src_b,
    input  logic [`EX_XLEN-1:0]  imm,
    output logic [`EX_XLEN-1:0]  operand_a,
    output logic [`EX_XLEN-1:0]  operand_b,
    output alu_ctrl_t            alu_ctrl
);

    always_comb begin
        // operand a
        case (opcode)
            `OPC_LUI:
                operand_a = '0;
            `OPC_AUIPC, `OPC_JAL,
            `OPC_BEQ, `OPC_BNE, `OPC_BLT, `OPC_BGE, `OPC_BLTU, `OPC_BGEU:
                operand_a = pc;
            // zero-extended low word, result sits in the low half
            `OPC_SLLIW, `OPC_SRLIW:
                operand_a = {32'b0, src_a[31:0]};
            // low word moved up so sra/srl see bit 31 as the sign
            `OPC_SRAIW, `OPC_SRLW, `OPC_SRAW:
                operand_a = {src_a[31:0], 32'b0};
            default:
                operand_a = src_a;
        endcase

        // operand b
        case (opcode)
            `OPC_LUI, `OPC_AUIPC, `OPC_JAL, `OPC_JALR,
            `OPC_BEQ, `OPC_BNE, `OPC_BLT, `OPC_BGE, `OPC_BLTU, `OPC_BGEU,
            `OPC_ADDI, `OPC_SLTI, `OPC_SLTIU, `OPC_XORI, `OPC_ORI, `OPC_ANDI,
            `OPC_ADDIW:
                operand_b = imm;
            // 6-bit shamt from the instruction
            `OPC_SLLI, `OPC_SRLI, `OPC_SRAI:
                operand_b = {58'b0, inst[25:20]};
            // 5-bit shamt for word forms
            `OPC_SLLIW, `OPC_SRLIW, `OPC_SRAIW:
                operand_b = {59'b0, inst[24:20]};
            `OPC_SLL, `OPC_SRL:
                operand_b = {58'b0, src_b[5:0]};
            `OPC_SLLW, `OPC_SRLW, `OPC_SRAW:
                operand_b = {59'b0, src_b[4:0]};
            default:
                operand_b = src_b;
        endcase

        // alu mode, add covers lui/auipc/jal/jalr/addi/branch targets
        case (opcode)
            `OPC_SUB, `OPC_SUBW:                  alu_ctrl.mode = ALU_SUB;
            `OPC_SLT, `OPC_SLTI:                  alu_ctrl.mode = ALU_SLT;
            `OPC_SLTU, `OPC_SLTIU:                alu_ctrl.mode = ALU_SLTU;
            `OPC_XOR, `OPC_XORI:                  alu_ctrl.mode = ALU_XOR;
            // csrrs forms src_a | src_b
            `OPC_OR, `OPC_ORI, `OPC_CSRRS:        alu_ctrl.mode = ALU_OR;
            `OPC_AND, `OPC_ANDI:                  alu_ctrl.mode = ALU_AND;
            `OPC_SLL, `OPC_SLLI,
            `OPC_SLLIW, `OPC_SLLW:                alu_ctrl.mode = ALU_SLL;
            `OPC_SRL, `OPC_SRLI,
            `OPC_SRLIW, `OPC_SRLW:                alu_ctrl.mode = ALU_SRL;
            `OPC_SRAI, `OPC_SRAIW, `OPC_SRAW:     alu_ctrl.mode = ALU_SRA;
            default:                              alu_ctrl.mode = ALU_ADD;
        endcase

        // W result formatting
        case (opcode)
            `OPC_SLLIW, `OPC_SRLIW, `OPC_ADDW, `OPC_SUBW, `OPC_SLLW, `OPC_ADDIW:
                alu_ctrl.word_fmt = FMT_SEXT_LOW;
            `OPC_SRAIW, `OPC_SRLW, `OPC_SRAW:
                alu_ctrl.word_fmt = FMT_SEXT_HIGH;
            default:
                alu_ctrl.word_fmt = FMT_NONE;
        endcase
    end

endmodule

// File: src/ex_alu.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_alu
    import ex_pkg::*;
(
    input  logic [`EX_XLEN-1:0] operand_a,
    input  logic [`EX_XLEN-1:0] operand_b,
    input  alu_ctrl_t           alu_ctrl,
    output logic [`EX_XLEN-1:0] alu_result
);

    logic [`EX_XLEN-1:0] raw;
    logic [5:0]          shamt;
    logic                lt_s;
    logic                lt_u;

    // operand select already masked the amount
    assign shamt = operand_b[5:0];
    assign lt_s  = $signed(operand_a) < $signed(operand_b);
    assign lt_u  = operand_a < operand_b;

    always_comb begin
        case (alu_ctrl.mode)
            ALU_ADD:  raw = operand_a + operand_b;
            ALU_SUB:  raw = operand_a - operand_b;
            ALU_SLT:  raw = {{(`EX_XLEN-1){1'b0}}, lt_s};
            ALU_SLTU: raw = {{(`EX_XLEN-1){1'b0}}, lt_u};
            ALU_AND:  raw = operand_a & operand_b;
            ALU_OR:   raw = operand_a | operand_b;
            ALU_XOR:  raw = operand_a ^ operand_b;
            ALU_SLL:  raw = operand_a << shamt;
            ALU_SRL:  raw = operand_a >> shamt;
            ALU_SRA:  raw = $signed(operand_a) >>> shamt;
            default:  raw = operand_a + operand_b;
        endcase
    end

    // sext of the word that holds the 32-bit result
    always_comb begin
        case (alu_ctrl.word_fmt)
            FMT_SEXT_LOW:  alu_result = {{32{raw[31]}}, raw[31:0]};
            // high half used when the operand was placed in bits 63:32
            FMT_SEXT_HIGH: alu_result = {{32{raw[63]}}, raw[63:32]};
            default:       alu_result = raw;
        endcase
    end

endmodule

// File: src/ex_branch_unit.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_branch_unit
    import ex_pkg::*;
(
    input  logic [`EX_XLEN-1:0]  pc,
    input  inst_u                inst,
    input  logic [`EX_OPC_W-1:0] opcode,
    input  logic [`EX_XLEN-1:0]  src_a,
    input  logic [`EX_XLEN-1:0]  src_b,
    input  logic [`EX_XLEN-1:0]  alu_result,
    output logic [`EX_XLEN-1:0]  dnpc,
    output logic                 pc_update
);

    logic [`EX_XLEN-1:0] imm_b;
    logic [`EX_XLEN-1:0] snpc;
    logic [`EX_XLEN-1:0] branch_target;
    logic                taken;

    // b-immediate reassembled from the scattered fields
    assign imm_b = {{51{inst.b.imm12}}, inst.b.imm12, inst.b.imm11,
                    inst.b.imm10_5, inst.b.imm4_1, 1'b0};
    assign snpc          = pc + 64'd4;
    assign branch_target = pc + imm_b;

    // branch conditions on the raw register values
    always_comb begin
        case (opcode)
            `OPC_BEQ:  taken = (src_a == src_b);
            `OPC_BNE:  taken = (src_a != src_b);
            `OPC_BLT:  taken = ($signed(src_a) < $signed(src_b));
            `OPC_BGE:  taken = ($signed(src_a) >= $signed(src_b));
            `OPC_BLTU: taken = (src_a < src_b);
            `OPC_BGEU: taken = (src_a >= src_b);
            default:   taken = 1'b0;
        endcase
    end

    always_comb begin
        pc_update = 1'b1;
        case (opcode)
            `OPC_JAL:  dnpc = alu_result;
            // jalr target has bit 0 cleared
            `OPC_JALR: dnpc = {alu_result[`EX_XLEN-1:1], 1'b0};
            `OPC_BEQ, `OPC_BNE, `OPC_BLT, `OPC_BGE, `OPC_BLTU, `OPC_BGEU:
                dnpc = taken ? branch_target : snpc;
            // trap vector and return address arrive on src_b
            `OPC_ECALL, `OPC_MRET:
                dnpc = src_b;
            default: begin
                dnpc      = snpc;
                pc_update = 1'b0;
            end
        endcase
    end

endmodule

// File: src/ex_csr_ctrl.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_csr_ctrl
    import ex_pkg::*;
(
    input  logic [`EX_XLEN-1:0]  pc,
    input  inst_u                inst,
    input  logic [`EX_OPC_W-1:0] opcode,
    input  logic [`EX_XLEN-1:0]  src_a,
    input  logic [`EX_XLEN-1:0]  alu_result,
    output csr_wr_t              csr_mtvec,
    output csr_wr_t              csr_mepc,
    output csr_wr_t              csr_mcause,
    output csr_wr_t              csr_mstatus
);

    logic                is_rw;
    logic                is_rw_rs;
    logic                is_ecall;
    logic [11:0]         addr;
    logic [`EX_XLEN-1:0] csr_data;

    // strobe plus data, data held at zero when idle
    function automatic csr_wr_t csr_write(input logic en, input logic [`EX_XLEN-1:0] data);
        csr_wr_t w;
        w.wen   = en;
        w.wdata = en ? data : '0;
        return w;
    endfunction

    assign addr     = inst.csr.csr;
    assign is_rw    = (opcode == `OPC_CSRRW);
    assign is_rw_rs = is_rw || (opcode == `OPC_CSRRS);
    assign is_ecall = (opcode == `OPC_ECALL);
    // csrrw writes rs1, csrrs writes the or from the alu
    assign csr_data = is_rw ? src_a : alu_result;

    // mtvec only written by csrrw
    assign csr_mtvec   = csr_write(is_rw && addr == `CSR_MTVEC, csr_data);
    assign csr_mstatus = csr_write(is_rw_rs && addr == `CSR_MSTATUS, csr_data);

    // ecall saves the trapping pc and the cause
    assign csr_mepc   = is_ecall ? csr_write(1'b1, pc)
                                 : csr_write(is_rw_rs && addr == `CSR_MEPC, csr_data);
    assign csr_mcause = is_ecall ? csr_write(1'b1, `MCAUSE_ECALL_M)
                                 : csr_write(is_rw_rs && addr == `CSR_MCAUSE, csr_data);

endmodule

// File: src/ex_stage.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module ex_stage
    import ex_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 valid_id_ex,
    input  ex_in_t               id_ex,
    output logic                 valid_ex_mem,
    output logic [`EX_XLEN-1:0]  pc_ex_mem,
    output logic [`EX_ILEN-1:0]  inst_ex_mem,
    output logic [`EX_OPC_W-1:0] opcode_ex_mem,
    output logic [`EX_XLEN-1:0]  src_b_ex_mem,
    output logic [`EX_XLEN-1:0]  alu_out_ex_mem,
    output logic [`EX_XLEN-1:0]  dnpc,
    output logic                 pc_update,
    output csr_wr_t              csr_mtvec,
    output csr_wr_t              csr_mepc,
    output csr_wr_t              csr_mcause,
    output csr_wr_t              csr_mstatus
);

    logic                valid_q;
    ex_in_t              id_q;
    ex_in_t              ex;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
    logic [`EX_XLEN-1:0] alu_result;
    alu_ctrl_t           alu_ctrl;

    // decode to execute register, no stall
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_q <= 1'b0;
            id_q    <= '0;
        end else begin
            valid_q <= valid_id_ex;
            id_q    <= id_ex;
        end
    end

    // bubble looks like an all-zero item, so no block sees a stale opcode
    assign ex = valid_q ? id_q : '0;

    // forwarded fields leave ungated
    assign valid_ex_mem   = valid_q;
    assign pc_ex_mem      = id_q.pc;
    assign inst_ex_mem    = id_q.inst;
    assign opcode_ex_mem  = id_q.opcode;
    assign src_b_ex_mem   = id_q.src_b;
    assign alu_out_ex_mem = alu_result;

    ex_operand_sel operand_sel_i (
        .pc        (ex.pc),
        .inst      (ex.inst),
        .opcode    (ex.opcode),
        .src_a     (ex.src_a),
        .src_b     (ex.src_b),
        .imm       (ex.imm),
        .operand_a (operand_a),
        .operand_b (operand_b),
        .alu_ctrl  (alu_ctrl)
    );

    ex_alu alu_i (
        .operand_a  (operand_a),
        .operand_b  (operand_b),
        .alu_ctrl   (alu_ctrl),
        .alu_result (alu_result)
    );

    ex_branch_unit branch_unit_i (
        .pc         (ex.pc),
        .inst       (ex.inst),
        .opcode     (ex.opcode),
        .src_a      (ex.src_a),
        .src_b      (ex.src_b),
        .alu_result (alu_result),
        .dnpc       (dnpc),
        .pc_update  (pc_update)
    );

    ex_csr_ctrl csr_ctrl_i (
        .pc          (ex.pc),
        .inst        (ex.inst),
        .opcode      (ex.opcode),
        .src_a       (ex.src_a),
        .alu_result  (alu_result),
        .csr_mtvec   (csr_mtvec),
        .csr_mepc    (csr_mepc),
        .csr_mcause  (csr_mcause),
        .csr_mstatus (csr_mstatus)
    );

endmodule

// File: verif/tb_ex_stage.sv
`timescale 1ns/1ns
`include "ex_config.svh"

module tb_ex_stage
    import ex_pkg::*;
();

    logic                 clk;
    logic                 rst;
    logic                 valid_id_ex;
    ex_in_t               id_ex;
    logic                 valid_ex_mem;
    logic [`EX_XLEN-1:0]  pc_ex_mem;
    logic [`EX_ILEN-1:0]  inst_ex_mem;
    logic [`EX_OPC_W-1:0] opcode_ex_mem;
    logic [`EX_XLEN-1:0]  src_b_ex_mem;
    logic [`EX_XLEN-1:0]  alu_out_ex_mem;
    logic [`EX_XLEN-1:0]  dnpc;
    logic                 pc_update;
    csr_wr_t              csr_mtvec;
    csr_wr_t              csr_mepc;
    csr_wr_t              csr_mcause;
    csr_wr_t              csr_mstatus;

    // reference model state lags the inputs by one cycle like the DUT
    logic                 armed;
    logic                 rst_q;
    logic                 exp_valid;
    ex_in_t               exp_item;
    logic                 exp_alu_chk;
    logic [`EX_XLEN-1:0]  exp_alu;
    logic                 exp_pcu;
    logic [`EX_XLEN-1:0]  exp_dnpc;
    csr_wr_t              exp_mtvec;
    csr_wr_t              exp_mepc;
    csr_wr_t              exp_mcause;
    csr_wr_t              exp_mstatus;
    logic [31:0]          rng;

    localparam logic [`EX_OPC_W-1:0] alu_ops [0:28] = '{
        `OPC_ADD, `OPC_SUB, `OPC_SLL, `OPC_SLT, `OPC_SLTU, `OPC_XOR, `OPC_SRL, `OPC_OR,
        `OPC_AND, `OPC_SLLIW, `OPC_SRLIW, `OPC_SRAIW, `OPC_ADDW, `OPC_SUBW, `OPC_SLLW,
        `OPC_SRLW, `OPC_SRAW, `OPC_LUI, `OPC_AUIPC, `OPC_SLLI, `OPC_SRLI, `OPC_SRAI,
        `OPC_ADDI, `OPC_SLTI, `OPC_SLTIU, `OPC_XORI, `OPC_ORI, `OPC_ANDI, `OPC_ADDIW};
    localparam logic [`EX_OPC_W-1:0] br_ops [0:5] = '{
        `OPC_BEQ, `OPC_BNE, `OPC_BLT, `OPC_BGE, `OPC_BLTU, `OPC_BGEU};
    // last entry is mscratch which this stage never writes
    localparam logic [11:0] csr_addrs [0:4] = '{
        `CSR_MTVEC, `CSR_MEPC, `CSR_MCAUSE, `CSR_MSTATUS, 12'h340};

    ex_stage ex_stage_i (
        .clk            (clk),
        .rst            (rst),
        .valid_id_ex    (valid_id_ex),
        .id_ex          (id_ex),
        .valid_ex_mem   (valid_ex_mem),
        .pc_ex_mem      (pc_ex_mem),
        .inst_ex_mem    (inst_ex_mem),
        .opcode_ex_mem  (opcode_ex_mem),
        .src_b_ex_mem   (src_b_ex_mem),
        .alu_out_ex_mem (alu_out_ex_mem),
        .dnpc           (dnpc),
        .pc_update      (pc_update),
        .csr_mtvec      (csr_mtvec),
        .csr_mepc       (csr_mepc),
        .csr_mcause     (csr_mcause),
        .csr_mstatus    (csr_mstatus)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1, "stopping on first error");
    endtask

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic draw64(output logic [63:0] v);
        rng = lcg_step(rng);
        v[63:32] = rng;
        rng = lcg_step(rng);
        v[31:0] = rng;
    endtask

    function automatic logic [63:0] sext_word(input logic [31:0] w);
        return {{32{w[31]}}, w};
    endfunction

    // rv64i result rules from the isa
    function automatic logic [63:0] ref_alu(input ex_in_t x);
        logic [63:0] a;
        logic [63:0] b;
        logic [5:0]  sh;
        a  = x.src_a;
        b  = x.src_b;
        sh = x.inst[25:20];
        case (x.opcode)
            `OPC_ADD:   return a + b;
            `OPC_SUB:   return a - b;
            `OPC_SLL:   return a << b[5:0];
            `OPC_SLT:   return {63'b0, $signed(a) < $signed(b)};
            `OPC_SLTU:  return {63'b0, a < b};
            `OPC_XOR:   return a ^ b;
            `OPC_SRL:   return a >> b[5:0];
            `OPC_OR:    return a | b;
            `OPC_AND:   return a & b;
            `OPC_SLLIW: return sext_word(a[31:0] << sh[4:0]);
            `OPC_SRLIW: return sext_word(a[31:0] >> sh[4:0]);
            `OPC_SRAIW: return sext_word($signed(a[31:0]) >>> sh[4:0]);
            `OPC_ADDW:  return sext_word(a[31:0] + b[31:0]);
            `OPC_SUBW:  return sext_word(a[31:0] - b[31:0]);
            `OPC_SLLW:  return sext_word(a[31:0] << b[4:0]);
            `OPC_SRLW:  return sext_word(a[31:0] >> b[4:0]);
            `OPC_SRAW:  return sext_word($signed(a[31:0]) >>> b[4:0]);
            `OPC_LUI:   return x.imm;
            `OPC_AUIPC: return x.pc + x.imm;
            `OPC_SLLI:  return a << sh;
            `OPC_SRLI:  return a >> sh;
            `OPC_SRAI:  return $signed(a) >>> sh;
            `OPC_ADDI:  return a + x.imm;
            `OPC_SLTI:  return {63'b0, $signed(a) < $signed(x.imm)};
            `OPC_SLTIU: return {63'b0, a < x.imm};
            `OPC_XORI:  return a ^ x.imm;
            `OPC_ORI:   return a | x.imm;
            `OPC_ANDI:  return a & x.imm;
            `OPC_ADDIW: return sext_word(a[31:0] + x.imm[31:0]);
            default:    return '0;
        endcase
    endfunction

    function automatic logic is_alu_op(input logic [`EX_OPC_W-1:0] op);
        for (int i = 0; i < 29; i++) begin
            if (alu_ops[i] == op)
                return 1'b1;
        end
        return 1'b0;
    endfunction

    // the ten opcodes that redirect fetch
    function automatic logic is_flow_op(input logic [`EX_OPC_W-1:0] op);
        case (op)
            `OPC_JAL, `OPC_JALR, `OPC_BEQ, `OPC_BNE, `OPC_BLT, `OPC_BGE,
            `OPC_BLTU, `OPC_BGEU, `OPC_ECALL, `OPC_MRET:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    function automatic logic [63:0] ref_dnpc(input ex_in_t x);
        logic [63:0] bimm;
        logic        taken;
        // b-type immediate from raw instruction bits
        bimm = {{52{x.inst[31]}}, x.inst[7], x.inst[30:25], x.inst[11:8], 1'b0};
        case (x.opcode)
            `OPC_BEQ:  taken = x.src_a == x.src_b;
            `OPC_BNE:  taken = x.src_a != x.src_b;
            `OPC_BLT:  taken = $signed(x.src_a) < $signed(x.src_b);
            `OPC_BGE:  taken = $signed(x.src_a) >= $signed(x.src_b);
            `OPC_BLTU: taken = x.src_a < x.src_b;
            `OPC_BGEU: taken = x.src_a >= x.src_b;
            default:   taken = 1'b0;
        endcase
        case (x.opcode)
            `OPC_JAL:              return x.pc + x.imm;
            `OPC_JALR:             return (x.src_a + x.imm) & ~64'd1;
            `OPC_ECALL, `OPC_MRET: return x.src_b;
            default:               return taken ? x.pc + bimm : x.pc + 64'd4;
        endcase
    endfunction

    // expected write port for one csr address
    function automatic csr_wr_t ref_csr(input ex_in_t x, input logic [11:0] target);
        csr_wr_t w;
        w = '0;
        if (x.opcode == `OPC_CSRRW && x.inst[31:20] == target) begin
            w.wen   = 1'b1;
            w.wdata = x.src_a;
        end else if (x.opcode == `OPC_CSRRS && x.inst[31:20] == target
                     && target != `CSR_MTVEC) begin
            w.wen   = 1'b1;
            w.wdata = x.src_a | x.src_b;
        end else if (x.opcode == `OPC_ECALL && target == `CSR_MEPC) begin
            w.wen   = 1'b1;
            w.wdata = x.pc;
        end else if (x.opcode == `OPC_ECALL && target == `CSR_MCAUSE) begin
            w.wen   = 1'b1;
            w.wdata = 64'd11;
        end
        return w;
    endfunction

    always @(posedge clk) begin
        rst_q <= rst;
        if (rst)
            armed <= 1'b1;
    end

    // model captures what the DUT register captures on the same edge
    always @(posedge clk) begin
        if (rst) begin
            exp_valid   <= 1'b0;
            exp_alu_chk <= 1'b0;
            exp_pcu     <= 1'b0;
            exp_mtvec   <= '0;
            exp_mepc    <= '0;
            exp_mcause  <= '0;
            exp_mstatus <= '0;
        end else begin
            exp_valid   <= valid_id_ex;
            exp_item    <= id_ex;
            exp_alu_chk <= valid_id_ex && is_alu_op(id_ex.opcode);
            exp_alu     <= ref_alu(id_ex);
            exp_pcu     <= valid_id_ex && is_flow_op(id_ex.opcode);
            exp_dnpc    <= ref_dnpc(id_ex);
            exp_mtvec   <= valid_id_ex ? ref_csr(id_ex, `CSR_MTVEC) : '0;
            exp_mepc    <= valid_id_ex ? ref_csr(id_ex, `CSR_MEPC) : '0;
            exp_mcause  <= valid_id_ex ? ref_csr(id_ex, `CSR_MCAUSE) : '0;
            exp_mstatus <= valid_id_ex ? ref_csr(id_ex, `CSR_MSTATUS) : '0;
        end
    end

    // outputs quiet while held in reset
    assert property (@(posedge clk) rst_q |-> (!valid_ex_mem && !pc_update
                     && !csr_mtvec.wen && !csr_mepc.wen && !csr_mcause.wen
                     && !csr_mstatus.wen))
        else abort_run($sformatf("CHECK FAILED at %0t: output active during reset", $time));

    assert property (@(posedge clk) armed |-> (valid_ex_mem == exp_valid))
        else abort_run($sformatf("CHECK FAILED at %0t: valid_ex_mem %b, expected %b",
                                 $time, $sampled(valid_ex_mem), $sampled(exp_valid)));

    assert property (@(posedge clk) (armed && exp_valid) |-> (pc_ex_mem == exp_item.pc
                     && inst_ex_mem == exp_item.inst && opcode_ex_mem == exp_item.opcode
                     && src_b_ex_mem == exp_item.src_b))
        else abort_run($sformatf("CHECK FAILED at %0t: forwarded fields differ, opcode %h",
                                 $time, $sampled(exp_item.opcode)));

    assert property (@(posedge clk) (armed && exp_alu_chk) |-> (alu_out_ex_mem == exp_alu))
        else abort_run($sformatf("CHECK FAILED at %0t: opcode %h alu_out %h, expected %h",
                                 $time, $sampled(exp_item.opcode), $sampled(alu_out_ex_mem),
                                 $sampled(exp_alu)));

    assert property (@(posedge clk) armed |-> (pc_update == exp_pcu))
        else abort_run($sformatf("CHECK FAILED at %0t: pc_update %b, expected %b",
                                 $time, $sampled(pc_update), $sampled(exp_pcu)));

    assert property (@(posedge clk) (armed && exp_valid) |-> (dnpc == exp_dnpc))
        else abort_run($sformatf("CHECK FAILED at %0t: opcode %h dnpc %h, expected %h",
                                 $time, $sampled(exp_item.opcode), $sampled(dnpc),
                                 $sampled(exp_dnpc)));

    assert property (@(posedge clk) armed |-> (csr_mtvec == exp_mtvec
                     && csr_mepc == exp_mepc && csr_mcause == exp_mcause
                     && csr_mstatus == exp_mstatus))
        else abort_run($sformatf("CHECK FAILED at %0t: csr write ports differ, opcode %h",
                                 $time, $sampled(exp_item.opcode)));

    task automatic random_item(input logic [`EX_OPC_W-1:0] op, output ex_in_t x);
        logic [63:0] r;
        draw64(r);
        x.pc = {r[63:2], 2'b00};
        draw64(r);
        x.inst = r[31:0];
        x.opcode = op;
        draw64(r);
        x.src_a = r;
        draw64(r);
        x.src_b = r;
        draw64(r);
        x.imm = r;
    endtask

    task automatic drive(input logic v, input ex_in_t x);
        @(posedge clk);
        valid_id_ex <= v;
        id_ex       <= x;
    endtask

    // polls at the falling edge up to 16 times
    task automatic wait_out_level(input logic level, input string what);
        int n;
        n = 0;
        while (valid_ex_mem !== level) begin
            if (n == 16)
                abort_run({"timeout waiting for ", what});
            else begin
                n++;
                @(negedge clk);
            end
        end
    endtask

    initial begin
        repeat (5000) @(posedge clk);
        abort_run("simulation did not finish within 5000 cycles");
    end

    initial begin
        ex_in_t      x;
        logic [63:0] r1;
        logic [63:0] r2;
        rst         = 1'b1;
        valid_id_ex = 1'b0;
        id_ex       = '0;
        armed       = 1'b0;
        rst_q       = 1'b0;
        rng         = 32'h0199_47b4;

        // valid ecall and csrrw traffic on the inputs while reset is held
        for (int k = 0; k < 8; k++) begin
            random_item(k[0] ? `OPC_CSRRW : `OPC_ECALL, x);
            x.inst[31:20] = k[1] ? `CSR_MTVEC : `CSR_MSTATUS;
            drive(1'b1, x);
        end
        rst         <= 1'b0;
        valid_id_ex <= 1'b0;

        random_item(`OPC_ADD, x);
        drive(1'b1, x);
        wait_out_level(1'b1, "valid_ex_mem after first item");

        // alu and word ops with about one bubble in eight
        for (int i = 0; i < 29; i++) begin
            for (int k = 0; k < 8; k++) begin
                random_item(alu_ops[i], x);
                draw64(r1);
                drive(r1[2:0] != 3'd0, x);
            end
        end

        // operands equal, mixed signs both ways and random
        for (int i = 0; i < 6; i++) begin
            for (int k = 0; k < 4; k++) begin
                random_item(br_ops[i], x);
                draw64(r1);
                draw64(r2);
                case (k)
                    0: begin
                        x.src_a = r1;
                        x.src_b = r1;
                    end
                    1: begin
                        x.src_a = {1'b1, r1[62:0]};
                        x.src_b = {1'b0, r2[62:0]};
                    end
                    2: begin
                        x.src_a = {1'b0, r1[62:0]};
                        x.src_b = {1'b1, r2[62:0]};
                    end
                    default: ;
                endcase
                drive(1'b1, x);
            end
        end

        for (int k = 0; k < 4; k++) begin
            random_item(`OPC_JAL, x);
            drive(1'b1, x);
            random_item(`OPC_JALR, x);
            drive(1'b1, x);
        end

        // csr writes to every address plus one the stage ignores
        for (int i = 0; i < 5; i++) begin
            random_item(`OPC_CSRRW, x);
            x.inst[31:20] = csr_addrs[i];
            drive(1'b1, x);
            random_item(`OPC_CSRRS, x);
            x.inst[31:20] = csr_addrs[i];
            drive(1'b1, x);
        end

        for (int k = 0; k < 2; k++) begin
            random_item(`OPC_ECALL, x);
            drive(1'b1, x);
            random_item(`OPC_MRET, x);
            drive(1'b1, x);
        end

        // bubbles carrying control flow and csr opcodes
        random_item(`OPC_JAL, x);
        drive(1'b0, x);
        random_item(`OPC_BEQ, x);
        drive(1'b0, x);
        random_item(`OPC_ECALL, x);
        drive(1'b0, x);
        random_item(`OPC_CSRRW, x);
        x.inst[31:20] = `CSR_MEPC;
        drive(1'b0, x);

        x = '0;
        drive(1'b0, x);
        wait_out_level(1'b0, "valid_ex_mem to drop at end");
        repeat (2) @(posedge clk);
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// File: src.f
+incdir+include
src/ex_pkg.sv
src/ex_operand_sel.sv
src/ex_alu.sv
src/ex_branch_unit.sv
src/ex_csr_ctrl.sv
src/ex_stage.sv
verif/tb_ex_stage.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the execute stage testbench with verilator
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 --top-module tb_ex_stage \
    -f src.f -o tb_ex_stage > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "verilator build failed, see build.log"
    exit 1
fi

./obj_dir/tb_ex_stage > "$log" 2>&1
sim_status=$?

if grep -q "CHECKS FAILED" "$log"; then
    echo "simulation reported failures, see $log"
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status, see $log"
    exit 1
fi
echo "simulation passed"
exit 0
